// ==== design/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and address width
`define CPU_W 16
// register count, index 0 is hardwired to zero
`define CPU_NREG 16

// opcodes, top nibble of the instruction word
`define CPU_OP_ADD  4'h0
`define CPU_OP_SUB  4'h1
`define CPU_OP_XOR  4'h2
// reduction add in the original family, reserved here
`define CPU_OP_RED  4'h3
`define CPU_OP_SLL  4'h4
`define CPU_OP_SRA  4'h5
`define CPU_OP_ROR  4'h6
// parallel sub-word add in the original family, reserved here
`define CPU_OP_PADD 4'h7
`define CPU_OP_LW   4'h8
`define CPU_OP_SW   4'h9
`define CPU_OP_LLB  4'hA
`define CPU_OP_LHB  4'hB
`define CPU_OP_B    4'hC
`define CPU_OP_BR   4'hD
`define CPU_OP_PCS  4'hE
`define CPU_OP_HLT  4'hF

// branch condition codes
`define CPU_CC_NE 3'd0
`define CPU_CC_EQ 3'd1
`define CPU_CC_GT 3'd2
`define CPU_CC_LT 3'd3
`define CPU_CC_GE 3'd4
`define CPU_CC_LE 3'd5
`define CPU_CC_OV 3'd6
`define CPU_CC_AL 3'd7

// write-back source select
`define CPU_WB_ALU 2'd0
`define CPU_WB_MEM 2'd1
`define CPU_WB_PC  2'd2

`endif

// ==== design/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // register-register format: ADD SUB XOR and the shifts
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } r_fmt_t;

  // byte immediate format: LLB and LHB
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rd;
    logic [7:0] imm8;
  } i_fmt_t;

  // memory format: LW and SW
  // off4 is a signed word offset, doubled before use
  typedef struct packed {
    logic [3:0] opcode;
    logic [3:0] rt;
    logic [3:0] rs;
    logic [3:0] off4;
  } m_fmt_t;

  // branch format: B, also the cond field of BR
  // imm9 is a signed word offset from pc plus 2
  typedef struct packed {
    logic [3:0] opcode;
    logic [2:0] cond;
    logic [8:0] imm9;
  } b_fmt_t;

  // one fetched word seen through each format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    m_fmt_t m_fmt;
    b_fmt_t b_fmt;
  } instr_u;

endpackage

`default_nettype wire

// ==== design/alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module alu (
  input  logic [3:0]        op,
  input  logic [`CPU_W-1:0] a,
  input  logic [`CPU_W-1:0] b,
  input  logic [7:0]        imm8,
  input  logic              half_load,
  output logic [`CPU_W-1:0] result,
  output logic              z_next,
  output logic              v_next,
  output logic              n_next
);

  logic [`CPU_W-1:0]   sum;
  logic [`CPU_W-1:0]   diff;
  logic                add_ovf;
  logic                sub_ovf;
  logic [`CPU_W-1:0]   sat_val;
  logic [3:0]          shamt;
  logic [2*`CPU_W-1:0] rot_wide;

  assign sum  = a + b;
  assign diff = a - b;

  // signed overflow when operand signs agree (add) or differ (sub)
  // and the result sign moves away from a
  assign add_ovf = (a[`CPU_W-1] == b[`CPU_W-1]) && (sum[`CPU_W-1] != a[`CPU_W-1]);
  assign sub_ovf = (a[`CPU_W-1] != b[`CPU_W-1]) && (diff[`CPU_W-1] != a[`CPU_W-1]);

  // clamp toward the sign of a, 8000 when negative else 7fff
  assign sat_val = a[`CPU_W-1] ? {1'b1, {(`CPU_W-1){1'b0}}} : {1'b0, {(`CPU_W-1){1'b1}}};

  // shift amount from the low nibble of the second operand
  assign shamt = b[3:0];

  // rotate right by shifting a doubled copy
  assign rot_wide = {a, a} >> shamt;

  always_comb begin
    result = '0;
    v_next = 1'b0;
    case (op)
      `CPU_OP_ADD: begin
        result = add_ovf ? sat_val : sum;
        v_next = add_ovf;
      end
      `CPU_OP_SUB: begin
        result = sub_ovf ? sat_val : diff;
        v_next = sub_ovf;
      end
      `CPU_OP_XOR: result = a ^ b;
      `CPU_OP_SLL: result = a << shamt;
      `CPU_OP_SRA: result = $signed(a) >>> shamt;
      `CPU_OP_ROR: result = rot_wide[`CPU_W-1:0];
      // reserved slots produce nothing
      `CPU_OP_RED,
      `CPU_OP_PADD: result = '0;
      `CPU_OP_LLB: begin
        if (half_load) begin
          result = {a[`CPU_W-1:8], imm8};
        end
      end
      `CPU_OP_LHB: begin
        if (half_load) begin
          result = {imm8, a[7:0]};
        end
      end
      default: result = '0;
    endcase
  end

  // flags come from the final, possibly saturated, value
  assign z_next = (result == '0);
  assign n_next = result[`CPU_W-1];

endmodule

`default_nettype wire

// ==== design/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module register_file (
  input  logic              clk,
  input  logic              rst,
  input  logic [3:0]        rs_idx,
  input  logic [3:0]        rt_idx,
  input  logic [3:0]        rd_idx,
  input  logic              wen,
  input  logic [`CPU_W-1:0] wdata,
  input  logic              z_in,
  input  logic              v_in,
  input  logic              n_in,
  input  logic              z_wen,
  input  logic              vn_wen,
  output logic [`CPU_W-1:0] rs_data,
  output logic [`CPU_W-1:0] rt_data,
  output logic              z,
  output logic              v,
  output logic              n
);

  logic [`CPU_W-1:0] regs [`CPU_NREG];

  // all registers clear on reset, writes to r0 are dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd_idx != 4'd0)) begin
      regs[rd_idx] <= wdata;
    end
  end

  // asynchronous reads, index zero forced to zero
  assign rs_data = (rs_idx == 4'd0) ? '0 : regs[rs_idx];
  assign rt_data = (rt_idx == 4'd0) ? '0 : regs[rt_idx];

  // flag register
  // z on every alu op, v and n on add and sub only
  always_ff @(posedge clk) begin
    if (rst) begin
      z <= 1'b0;
      v <= 1'b0;
      n <= 1'b0;
    end else begin
      if (z_wen) begin
        z <= z_in;
      end
      if (vn_wen) begin
        v <= v_in;
        n <= n_in;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/pc_control.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module pc_control
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  instr_u            instr,
  input  logic [`CPU_W-1:0] rs_data,
  input  logic              z,
  input  logic              v,
  input  logic              n,
  output logic [`CPU_W-1:0] pc,
  output logic [`CPU_W-1:0] pc_plus2
);

  logic              taken;
  logic [`CPU_W-1:0] br_target;
  logic [`CPU_W-1:0] pc_next;

  assign pc_plus2 = pc + `CPU_W'd2;

  // imm9 counts words, sign extend then double
  assign br_target = pc_plus2 + {{(`CPU_W-10){instr.b_fmt.imm9[8]}}, instr.b_fmt.imm9, 1'b0};

  // condition check against the stored flags
  always_comb begin
    case (instr.b_fmt.cond)
      `CPU_CC_NE: taken = !z;
      `CPU_CC_EQ: taken = z;
      `CPU_CC_GT: taken = !z && !n;
      `CPU_CC_LT: taken = n;
      `CPU_CC_GE: taken = z || !n;
      `CPU_CC_LE: taken = n || z;
      `CPU_CC_OV: taken = v;
      `CPU_CC_AL: taken = 1'b1;
      default:    taken = 1'b0;
    endcase
  end

  always_comb begin
    case (instr.b_fmt.opcode)
      `CPU_OP_B:   pc_next = taken ? br_target : pc_plus2;
      `CPU_OP_BR:  pc_next = taken ? rs_data : pc_plus2;
      // halt parks the pc on itself until reset
      `CPU_OP_HLT: pc_next = pc;
      default:     pc_next = pc_plus2;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module instr_decode
  import cpu_pkg::*;
(
  input  instr_u     instr,
  output logic [3:0] rs_idx,
  output logic [3:0] rt_idx,
  output logic [3:0] rd_idx,
  output logic       reg_wen,
  output logic       mem_wen,
  output logic [1:0] wb_sel,
  output logic       half_load,
  output logic       z_wen,
  output logic       vn_wen,
  output logic       halt
);

  logic [3:0] opcode;
  logic       alu_op;
  logic       is_lw;
  logic       is_sw;
  logic       is_pcs;

  assign opcode = instr.r_fmt.opcode;

  // the six real compute ops, reserved 3 and 7 excluded
  assign alu_op = (opcode == `CPU_OP_ADD) || (opcode == `CPU_OP_SUB) ||
                  (opcode == `CPU_OP_XOR) || (opcode == `CPU_OP_SLL) ||
                  (opcode == `CPU_OP_SRA) || (opcode == `CPU_OP_ROR);

  assign is_lw     = (opcode == `CPU_OP_LW);
  assign is_sw     = (opcode == `CPU_OP_SW);
  assign is_pcs    = (opcode == `CPU_OP_PCS);
  assign half_load = (opcode == `CPU_OP_LLB) || (opcode == `CPU_OP_LHB);
  assign halt      = (opcode == `CPU_OP_HLT);

  // destination sits in the same nibble for r, i and m formats
  assign rd_idx = instr.r_fmt.rd;

  // byte loads read back their own destination to merge into
  assign rs_idx = half_load ? instr.i_fmt.rd : instr.r_fmt.rs;

  // store data register is in the m format rt slot
  assign rt_idx = is_sw ? instr.m_fmt.rt : instr.r_fmt.rt;

  assign reg_wen = alu_op || is_lw || half_load || is_pcs;
  assign mem_wen = is_sw;

  // flag enables
  assign z_wen  = alu_op;
  assign vn_wen = (opcode == `CPU_OP_ADD) || (opcode == `CPU_OP_SUB);

  always_comb begin
    if (is_lw) begin
      wb_sel = `CPU_WB_MEM;
    end else if (is_pcs) begin
      wb_sel = `CPU_WB_PC;
    end else begin
      wb_sel = `CPU_WB_ALU;
    end
  end

endmodule

`default_nettype wire

// ==== design/cpu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module cpu
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  instr_u            instr,
  input  logic [`CPU_W-1:0] data_rdata,
  output logic [`CPU_W-1:0] pc,
  output logic              hlt,
  output logic [`CPU_W-1:0] data_addr,
  output logic [`CPU_W-1:0] data_wdata,
  output logic              data_wen,
  output logic              wb_en,
  output logic [3:0]        wb_reg,
  output logic [`CPU_W-1:0] wb_data
);

  // decode outputs
  logic [3:0] rs_idx;
  logic [3:0] rt_idx;
  logic [3:0] rd_idx;
  logic       reg_wen;
  logic       mem_wen;
  logic [1:0] wb_sel;
  logic       half_load;
  logic       z_wen;
  logic       vn_wen;

  // register file and flags
  logic [`CPU_W-1:0] rs_data;
  logic [`CPU_W-1:0] rt_data;
  logic              z;
  logic              v;
  logic              n;

  // alu result and next flags
  logic [`CPU_W-1:0] alu_out;
  logic              z_next;
  logic              v_next;
  logic              n_next;

  logic [`CPU_W-1:0] pc_plus2;

  instr_decode u_decode (
    .instr     (instr),
    .rs_idx    (rs_idx),
    .rt_idx    (rt_idx),
    .rd_idx    (rd_idx),
    .reg_wen   (reg_wen),
    .mem_wen   (mem_wen),
    .wb_sel    (wb_sel),
    .half_load (half_load),
    .z_wen     (z_wen),
    .vn_wen    (vn_wen),
    .halt      (hlt)
  );

  register_file u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rs_idx  (rs_idx),
    .rt_idx  (rt_idx),
    .rd_idx  (rd_idx),
    .wen     (reg_wen),
    .wdata   (wb_data),
    .z_in    (z_next),
    .v_in    (v_next),
    .n_in    (n_next),
    .z_wen   (z_wen),
    .vn_wen  (vn_wen),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .z       (z),
    .v       (v),
    .n       (n)
  );

  alu u_alu (
    .op        (instr.r_fmt.opcode),
    .a         (rs_data),
    .b         (rt_data),
    .imm8      (instr.i_fmt.imm8),
    .half_load (half_load),
    .result    (alu_out),
    .z_next    (z_next),
    .v_next    (v_next),
    .n_next    (n_next)
  );

  pc_control u_pc (
    .clk      (clk),
    .rst      (rst),
    .instr    (instr),
    .rs_data  (rs_data),
    .z        (z),
    .v        (v),
    .n        (n),
    .pc       (pc),
    .pc_plus2 (pc_plus2)
  );

  // word aligned base plus doubled signed offset
  assign data_addr = {rs_data[`CPU_W-1:1], 1'b0} +
                     {{(`CPU_W-5){instr.m_fmt.off4[3]}}, instr.m_fmt.off4, 1'b0};
  assign data_wdata = rt_data;
  assign data_wen   = mem_wen;

  // write-back source
  always_comb begin
    case (wb_sel)
      `CPU_WB_MEM: wb_data = data_rdata;
      `CPU_WB_PC:  wb_data = pc_plus2;
      default:     wb_data = alu_out;
    endcase
  end

  // retire trace, writes to r0 are dropped and so not shown
  assign wb_reg = rd_idx;
  assign wb_en  = reg_wen && (rd_idx != 4'd0);

endmodule

`default_nettype wire

// ==== test/cpu_ref_model.svh ====
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

// architectural state, one step per instruction
logic [`CPU_W-1:0] ref_regs [`CPU_NREG];
logic              ref_z;
logic              ref_v;
logic              ref_n;
logic [`CPU_W-1:0] ref_pc;
logic [`CPU_W-1:0] ref_mem [256];

// what the core should present for the word at ref_pc
logic              exp_hlt;
logic              exp_wb_en;
logic [3:0]        exp_wb_reg;
logic [`CPU_W-1:0] exp_wb_data;
logic              exp_mem_access;
logic              exp_data_wen;
logic [`CPU_W-1:0] exp_data_addr;
logic [`CPU_W-1:0] exp_data_wdata;

task automatic reset_model();
  for (int i = 0; i < `CPU_NREG; i++) begin
    ref_regs[i] = '0;
  end
  ref_z = 1'b0;
  ref_v = 1'b0;
  ref_n = 1'b0;
  ref_pc = '0;
endtask

// bit 16 says the signed total did not fit and was clamped
function automatic logic [16:0] clamp_sum(input int total);
  if (total > 32767) return {1'b1, 16'h7fff};
  if (total < -32768) return {1'b1, 16'h8000};
  return {1'b0, total[15:0]};
endfunction

// ge and le are gt or eq and lt or eq, since z and n update apart
function automatic logic cond_holds(input logic [2:0] cond);
  case (cond)
    `CPU_CC_NE: return !ref_z;
    `CPU_CC_EQ: return ref_z;
    `CPU_CC_GT: return !ref_z && !ref_n;
    `CPU_CC_LT: return ref_n;
    `CPU_CC_GE: return ref_z || (!ref_z && !ref_n);
    `CPU_CC_LE: return ref_n || ref_z;
    `CPU_CC_OV: return ref_v;
    default:    return 1'b1;
  endcase
endfunction

task automatic execute_instr(input instr_u w);
  logic [`CPU_W-1:0] a;
  logic [`CPU_W-1:0] b;
  logic [`CPU_W-1:0] res;
  logic [`CPU_W-1:0] next_pc;
  logic [16:0]       clamped;
  logic [3:0]        dest;
  logic              write;
  logic              alu_op;
  int                sa;
  int                sb;
  int                amt;
  a = ref_regs[w.r_fmt.rs];
  b = ref_regs[w.r_fmt.rt];
  sa = $signed(a);
  sb = $signed(b);
  amt = b[3:0];
  res = '0;
  dest = w.r_fmt.rd;
  write = 1'b0;
  alu_op = 1'b0;
  next_pc = ref_pc + 16'd2;
  exp_hlt = 1'b0;
  exp_mem_access = 1'b0;
  exp_data_wen = 1'b0;
  exp_data_addr = '0;
  exp_data_wdata = '0;
  case (w.r_fmt.opcode)
    `CPU_OP_ADD, `CPU_OP_SUB: begin
      clamped = (w.r_fmt.opcode == `CPU_OP_ADD) ? clamp_sum(sa + sb) : clamp_sum(sa - sb);
      res = clamped[15:0];
      ref_v = clamped[16];
      ref_n = res[15];
      alu_op = 1'b1;
    end
    `CPU_OP_XOR: begin
      res = a ^ b;
      alu_op = 1'b1;
    end
    `CPU_OP_SLL: begin
      res = a << amt;
      alu_op = 1'b1;
    end
    `CPU_OP_SRA: begin
      res = $signed(a) >>> amt;
      alu_op = 1'b1;
    end
    `CPU_OP_ROR: begin
      // one bit at a time, lsb wraps to msb
      res = a;
      repeat (amt) res = {res[0], res[15:1]};
      alu_op = 1'b1;
    end
    `CPU_OP_LW, `CPU_OP_SW: begin
      dest = w.m_fmt.rt;
      exp_mem_access = 1'b1;
      // even base, offset counted in words
      exp_data_addr = (a & 16'hfffe) + 16'(2 * $signed(w.m_fmt.off4));
      if (w.r_fmt.opcode == `CPU_OP_LW) begin
        res = ref_mem[exp_data_addr[8:1]];
        write = 1'b1;
      end else begin
        exp_data_wen = 1'b1;
        exp_data_wdata = ref_regs[dest];
        ref_mem[exp_data_addr[8:1]] = exp_data_wdata;
      end
    end
    `CPU_OP_LLB: begin
      res = {ref_regs[w.i_fmt.rd][15:8], w.i_fmt.imm8};
      write = 1'b1;
    end
    `CPU_OP_LHB: begin
      res = {w.i_fmt.imm8, ref_regs[w.i_fmt.rd][7:0]};
      write = 1'b1;
    end
    `CPU_OP_B: begin
      if (cond_holds(w.b_fmt.cond)) begin
        next_pc = ref_pc + 16'd2 + 16'(2 * $signed(w.b_fmt.imm9));
      end
    end
    `CPU_OP_BR: begin
      if (cond_holds(w.b_fmt.cond)) next_pc = a;
    end
    `CPU_OP_PCS: begin
      res = ref_pc + 16'd2;
      write = 1'b1;
    end
    `CPU_OP_HLT: begin
      next_pc = ref_pc;
      exp_hlt = 1'b1;
    end
    // reserved opcodes change nothing
    default: ;
  endcase
  if (alu_op) begin
    ref_z = (res == '0);
    write = 1'b1;
  end
  exp_wb_en = write && (dest != 4'd0);
  exp_wb_reg = dest;
  exp_wb_data = res;
  if (exp_wb_en) ref_regs[dest] = res;
  ref_pc = next_pc;
endtask

`endif

// ==== test/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb
  import cpu_pkg::*;
();

  localparam int NUM_PROGS  = 20;
  localparam int PROG_LEN   = 128;
  localparam int MAX_CYCLES = 2000;

  logic              clk;
  logic              rst;
  instr_u            instr;
  logic [`CPU_W-1:0] data_rdata;
  logic [`CPU_W-1:0] pc;
  logic              hlt;
  logic [`CPU_W-1:0] data_addr;
  logic [`CPU_W-1:0] data_wdata;
  logic              data_wen;
  logic              wb_en;
  logic [3:0]        wb_reg;
  logic [`CPU_W-1:0] wb_data;

  logic [`CPU_W-1:0] prog [PROG_LEN];
  logic [`CPU_W-1:0] dmem [256];

  `include "cpu_ref_model.svh"

  cpu dut (
    .clk        (clk),
    .rst        (rst),
    .instr      (instr),
    .data_rdata (data_rdata),
    .pc         (pc),
    .hlt        (hlt),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_wen   (data_wen),
    .wb_en      (wb_en),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // program memory, any pc past the program fetches hlt
  assign instr = (pc < 2 * PROG_LEN) ? prog[pc[7:1]] : {`CPU_OP_HLT, 12'h000};

  // data memory, word indexed, written on the edge
  assign data_rdata = dmem[data_addr[8:1]];
  always @(posedge clk) begin
    if (data_wen) dmem[data_addr[8:1]] <= data_wdata;
  end

  function automatic logic [`CPU_W-1:0] fetch_word(input logic [`CPU_W-1:0] addr);
    if (addr < 2 * PROG_LEN) return prog[addr[7:1]];
    return {`CPU_OP_HLT, 12'h000};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`CPU_W-1:0] got,
                            input logic [`CPU_W-1:0] exp);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s got %h expected %h",
                                         $time, name, got, exp));
  endtask

  task automatic check_pc(input logic [`CPU_W-1:0] got, input logic [`CPU_W-1:0] exp);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: pc got %h expected %h",
                                         $time, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: %s got %b expected %b",
                                         $time, name, got, exp));
  endtask

  task automatic check_instr(input instr_u got, input instr_u exp);
    if (got !== exp) abort_run($sformatf("mismatch at %0t: instr got %h expected %h",
                                         $time, got, exp));
  endtask

  // branches only go forward and land on a slot start, so every program ends
  task automatic load_program();
    bit          starts [PROG_LEN + 16];
    bit          group [PROG_LEN];
    logic [31:0] w;
    logic [15:0] target;
    logic [3:0]  op;
    logic [3:0]  r;
    int          i;
    int          t;
    for (i = 0; i < PROG_LEN + 16; i++) starts[i] = (i >= PROG_LEN - 1);
    for (i = 0; i < PROG_LEN; i++) group[i] = 1'b0;
    // plain single words, now and then a three word register branch
    i = 0;
    while (i < PROG_LEN - 1) begin
      starts[i] = 1'b1;
      if (($urandom % 12 == 0) && (i + 3 <= PROG_LEN - 1)) begin
        group[i] = 1'b1;
        i = i + 3;
      end else begin
        i = i + 1;
      end
    end
    for (i = 0; i < PROG_LEN - 1; i++) begin
      w = $urandom;
      if (group[i]) begin
        // llb and lhb build a forward target, then br jumps through it
        t = i + 3 + $urandom % 6;
        while (!starts[t]) t++;
        target = t * 2;
        r = 4'd1 + $urandom % 15;
        prog[i] = {`CPU_OP_LLB, r, target[7:0]};
        prog[i + 1] = {`CPU_OP_LHB, r, target[15:8]};
        prog[i + 2] = {`CPU_OP_BR, w[11:8], r, w[3:0]};
      end else if (starts[i]) begin
        op = w[15:12];
        // br and hlt only where they are placed on purpose
        if (op == `CPU_OP_BR || op == `CPU_OP_HLT) op = {1'b0, w[14:12]};
        if (op == `CPU_OP_B) begin
          t = $urandom % 8;
          while (!starts[i + 1 + t]) t++;
          prog[i] = {op, w[11:9], 9'(t)};
        end else begin
          prog[i] = {op, w[11:0]};
        end
      end
    end
    prog[PROG_LEN - 1] = {`CPU_OP_HLT, 12'h000};
  endtask

  task automatic step_and_check(output bit halted);
    logic [`CPU_W-1:0] w;
    // the word on the bus must be the one at the model's pc
    w = fetch_word(ref_pc);
    check_instr(instr, w);
    check_pc(pc, ref_pc);
    execute_instr(w);
    check_bit("hlt", hlt, exp_hlt);
    check_bit("wb_en", wb_en, exp_wb_en);
    check_bit("data_wen", data_wen, exp_data_wen);
    if (exp_wb_en) begin
      check_word("wb_reg", {12'h000, wb_reg}, {12'h000, exp_wb_reg});
      check_word("wb_data", wb_data, exp_wb_data);
    end
    if (exp_mem_access) check_word("data_addr", data_addr, exp_data_addr);
    if (exp_data_wen) check_word("data_wdata", data_wdata, exp_data_wdata);
    halted = exp_hlt;
  endtask

  task automatic run_program(input int prog_idx);
    bit halted;
    int cycles;
    // new program goes in while the core is held in reset
    @(posedge clk);
    #1;
    rst = 1'b1;
    load_program();
    repeat (4) @(posedge clk);
    #1;
    for (int i = 0; i < 256; i++) begin
      dmem[i] = $urandom;
      ref_mem[i] = dmem[i];
    end
    reset_model();
    rst = 1'b0;
    halted = 1'b0;
    cycles = 0;
    while (!halted) begin
      if (cycles == MAX_CYCLES) begin
        abort_run($sformatf("timeout: program %0d did not halt within %0d cycles",
                            prog_idx, MAX_CYCLES));
      end
      @(negedge clk);
      step_and_check(halted);
      cycles++;
    end
    // one more cycle, pc parked and hlt still up
    @(negedge clk);
    check_pc(pc, ref_pc);
    check_bit("hlt", hlt, 1'b1);
  endtask

  initial begin
    logic [31:0] seed_ret;
    rst = 1'b1;
    seed_ret = $urandom(32'h2aba_32de);
    for (int i = 0; i < PROG_LEN; i++) prog[i] = {`CPU_OP_HLT, 12'h000};
    for (int i = 0; i < 256; i++) dmem[i] = '0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      run_program(p);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+design
+incdir+test
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/pc_control.sv
design/instr_decode.sv
design/cpu.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/alu.sv
      - design/register_file.sv
      - design/pc_control.sv
      - design/instr_decode.sv
      - design/cpu.sv
  - target: test
    include_dirs:
      - design
      - test
    files:
      - test/cpu_tb.sv
